// File: logic/irq_latch.sv
// ==============================
// interrupt latch
// raster and frame pending bits,
// cpu acknowledge, irq output
// ==============================
module irq_latch (
    input  logic                    clk,
    input  logic                    rst,
    input  raster_pkg::raster_wr_t  cpu,
    input  raster_pkg::video_sync_t sync,
    input  logic                    raster_event,
    output logic [15:0]             irq_rd_data,
    output logic                    irq
);
    import raster_pkg::*;

    logic       ev_q;     // raster_event one clk late
    logic       ev_rise;  // rising edge of raster_event
    logic       frame_set;
    logic       ack_wr;   // cpu write to REG_IRQ
    logic [1:0] pend;     // pending bits, readback layout
    logic [1:0] set_bits;
    logic [1:0] clr_bits;

    // event is a level, only its rise counts
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ev_q <= 1'b0;
        end else begin
            ev_q <= raster_event;
        end
    end

    assign ev_rise   = raster_event && !ev_q;
    assign frame_set = sync.pxl_cen && sync.frame_start; // one clk per frame

    // acknowledge decode
    assign ack_wr = cpu.wr && (cpu.addr == REG_IRQ);

    always_comb begin
        set_bits = '0;
        clr_bits = '0;
        set_bits[IRQ_RASTER_BIT] = ev_rise;
        set_bits[IRQ_FRAME_BIT]  = frame_set;
        if (ack_wr) begin
            clr_bits[IRQ_RASTER_BIT] = cpu.data[IRQ_RASTER_BIT];
            clr_bits[IRQ_FRAME_BIT]  = cpu.data[IRQ_FRAME_BIT];
        end
    end

    // a set in the same cycle as a clear wins
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pend <= '0;
        end else begin
            pend <= (pend & ~clr_bits) | set_bits;
        end
    end

    assign irq = |pend; // one line to the cpu

    // status readback, bits 1:0 only
    always_ff @(posedge clk) begin
        if (cpu.rd) begin
            irq_rd_data <= {14'd0, pend};
        end
    end

endmodule

// File: logic/raster_counter.sv
// ==============================
// raster line counter
// reloadable enable-gated down
// counter, zero flag, readback
// ==============================
module raster_counter #(
    parameter int CNT_W = 9 // count width
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             restart, // frame start, reload
    input  logic             step,    // line start, count down
    input  logic             we,      // cpu write to this counter
    input  logic             en_in,   // enable from write data
    input  logic [CNT_W-1:0] din,     // start value from write data
    output logic [CNT_W-1:0] dout,    // readback
    output logic             zero
);

    logic [CNT_W-1:0] cnt_start; // programmed start value
    logic [CNT_W-1:0] cnt;       // live count
    logic             enable;

    // count sits at the start value while disabled
    assign dout = cnt;
    assign zero = cnt == '0;

    // programming registers, written by cpu only
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt_start <= '0;
            enable    <= 1'b0;
        end else if (we) begin
            cnt_start <= din;
            enable    <= en_in;
        end
    end

    // count register
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt <= '0;
        end else if (we) begin
            cnt <= din; // write loads at once
        end else if (restart || !enable) begin
            // frame reload wins over the line step at pixel 0 of line 0
            cnt <= cnt_start;
        end else if (step) begin
            cnt <= cnt - 1'b1; // wraps past zero
        end
    end

endmodule

// File: logic/raster_irq_top.sv
// ==============================
// raster interrupt block top
// timing generator, raster unit,
// irq latch, cpu read return
// ==============================
module raster_irq_top #(
    parameter int H_TOTAL = 512, // pixels per line
    parameter int V_TOTAL = 262, // lines per frame
    parameter int PXL_DIV = 4,   // clk cycles per pixel
    parameter int CNT_W   = 9    // raster counter width
) (
    input  logic                   clk,
    input  logic                   rst,
    input  raster_pkg::raster_wr_t cpu,
    output logic [15:0]            rd_data,
    output logic                   rd_valid,
    output logic                   irq
);
    import raster_pkg::*;

    video_sync_t sync;         // shared timing strobes
    logic [15:0] cnt_rd_data;  // counter readback
    logic [15:0] irq_rd_data;  // pending bits readback
    logic        raster_event;
    raster_reg_e rd_addr;      // address of the read in flight

    video_timing #(
        .H_TOTAL (H_TOTAL),
        .V_TOTAL (V_TOTAL),
        .PXL_DIV (PXL_DIV)
    ) timing_i (
        .clk     (clk),
        .rst     (rst),
        .sync    (sync)
    );

    raster_unit #(
        .CNT_W        (CNT_W)
    ) unit_i (
        .clk          (clk),
        .rst          (rst),
        .cpu          (cpu),
        .sync         (sync),
        .cnt_rd_data  (cnt_rd_data),
        .raster_event (raster_event)
    );

    irq_latch latch_i (
        .clk          (clk),
        .rst          (rst),
        .cpu          (cpu),
        .sync         (sync),
        .raster_event (raster_event),
        .irq_rd_data  (irq_rd_data),
        .irq          (irq)
    );

    // read answered one clk after the strobe
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= cpu.rd;
        end
    end

    always_ff @(posedge clk) begin
        if (cpu.rd) begin
            rd_addr <= cpu.addr; // selects the readback source
        end
    end

    assign rd_data = (rd_addr == REG_IRQ) ? irq_rd_data : cnt_rd_data;

endmodule

// File: logic/raster_pkg.sv
// ==============================
// raster interrupt shared types
// cpu register map enum, cpu access
// struct, video sync strobe struct
// ==============================
package raster_pkg;

    // cpu register map, 2-bit address
    typedef enum logic [1:0] {
        REG_CNT0 = 2'd0, // line counter 0
        REG_CNT1 = 2'd1, // line counter 1
        REG_CNT2 = 2'd2, // line counter 2, gates the event
        REG_IRQ  = 2'd3  // pending bits / acknowledge
    } raster_reg_e;

    // one cpu access per cycle, strobes only
    typedef struct packed {
        logic        wr;   // write strobe
        logic        rd;   // read strobe
        raster_reg_e addr;
        logic [15:0] data; // write payload
    } raster_wr_t;

    // video timing strobes, all aligned to pxl_cen
    typedef struct packed {
        logic pxl_cen;     // one clk per pixel
        logic line_start;  // pixel 0 of each line
        logic frame_start; // pixel 0 of line 0
    } video_sync_t;

    // counter write layout
    localparam int CNT_EN_BIT = 15; // enable bit in data

    // interrupt register layout, same bits for ack and readback
    localparam int IRQ_RASTER_BIT = 0;
    localparam int IRQ_FRAME_BIT  = 1;

endpackage

// File: logic/raster_unit.sv
// ==============================
// raster unit
// three line counters, cpu write
// decode, readback, raster event
// ==============================
module raster_unit #(
    parameter int CNT_W = 9 // counter width
) (
    input  logic                    clk,
    input  logic                    rst,
    input  raster_pkg::raster_wr_t  cpu,
    input  raster_pkg::video_sync_t sync,
    output logic [15:0]             cnt_rd_data,
    output logic                    raster_event
);
    import raster_pkg::*;

    localparam int N_CNT = 3;

    logic [N_CNT-1:0] we;                  // per-counter write enable
    logic [N_CNT-1:0] zero;                // per-counter zero flag
    logic [CNT_W-1:0] cnt_dout [N_CNT];    // per-counter readback
    logic [CNT_W-1:0] din;
    logic             en_in;
    logic             restart;
    logic             step;
    logic             event_cond;

    // shared write payload
    assign din   = cpu.data[CNT_W-1:0];
    assign en_in = cpu.data[CNT_EN_BIT];

    // strobes qualified to one clk each
    assign restart = sync.pxl_cen && sync.frame_start;
    assign step    = sync.pxl_cen && sync.line_start;

    // counters 0..2 sit at addresses 0..2
    for (genvar i = 0; i < N_CNT; i++) begin : g_cnt
        assign we[i] = cpu.wr && (cpu.addr == raster_reg_e'(i));

        raster_counter #(
            .CNT_W   (CNT_W)
        ) cnt_i (
            .clk     (clk),
            .rst     (rst),
            .restart (restart),
            .step    (step),
            .we      (we[i]),
            .en_in   (en_in),
            .din     (din),
            .dout    (cnt_dout[i]),
            .zero    (zero[i])
        );
    end

    // counter 2 qualifies, either of 0 and 1 triggers
    assign event_cond = zero[2] && (zero[0] || zero[1]);

    // event is level, high while the condition holds
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            raster_event <= 1'b0;
        end else begin
            raster_event <= event_cond;
        end
    end

    // readback captured on the read strobe, top picks it up next cycle
    always_ff @(posedge clk) begin
        if (cpu.rd) begin
            case (cpu.addr)
                REG_CNT0: cnt_rd_data <= 16'(cnt_dout[0]); // zero-extend
                REG_CNT1: cnt_rd_data <= 16'(cnt_dout[1]);
                REG_CNT2: cnt_rd_data <= 16'(cnt_dout[2]);
                default:  cnt_rd_data <= '0; // irq register, not ours
            endcase
        end
    end

endmodule

// File: logic/video_timing.sv
// ==============================
// video timing generator
// pixel enable divider, h/v counters
// line and frame start strobes
// ==============================
module video_timing #(
    parameter int H_TOTAL = 512, // pixels per line
    parameter int V_TOTAL = 262, // lines per frame
    parameter int PXL_DIV = 4    // clk cycles per pixel
) (
    input  logic                    clk,
    input  logic                    rst,
    output raster_pkg::video_sync_t sync
);

    // counter widths, kept at least one bit wide
    localparam int DIV_W = (PXL_DIV > 1) ? $clog2(PXL_DIV) : 1;
    localparam int H_W   = (H_TOTAL > 1) ? $clog2(H_TOTAL) : 1;
    localparam int V_W   = (V_TOTAL > 1) ? $clog2(V_TOTAL) : 1;

    logic [DIV_W-1:0] div_cnt; // clk count inside one pixel
    logic [H_W-1:0]   h_cnt;   // pixel in line
    logic [V_W-1:0]   v_cnt;   // line in frame
    logic             pxl_cen;
    logic             h_last;  // last pixel of the line
    logic             v_last;  // last line of the frame

    // last clk of the pixel gives the enable
    // with PXL_DIV of 1 div_cnt stays at 0 and pxl_cen is always high
    assign pxl_cen = div_cnt == DIV_W'(PXL_DIV - 1);
    assign h_last  = h_cnt == H_W'(H_TOTAL - 1);
    assign v_last  = v_cnt == V_W'(V_TOTAL - 1);

    // pixel enable divider
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            div_cnt <= '0;
        end else if (pxl_cen) begin
            div_cnt <= '0; // wrap at PXL_DIV
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // horizontal counter, one step per pixel
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            h_cnt <= '0;
        end else if (pxl_cen) begin
            if (h_last) begin
                h_cnt <= '0;
            end else begin
                h_cnt <= h_cnt + 1'b1;
            end
        end
    end

    // vertical counter, steps on the last pixel of a line
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            v_cnt <= '0;
        end else if (pxl_cen && h_last) begin
            if (v_last) begin
                v_cnt <= '0; // next frame
            end else begin
                v_cnt <= v_cnt + 1'b1;
            end
        end
    end

    // strobes decoded from position 0
    // they last a whole pixel, consumers qualify with pxl_cen
    assign sync.pxl_cen     = pxl_cen;
    assign sync.line_start  = h_cnt == '0;
    assign sync.frame_start = (h_cnt == '0) && (v_cnt == '0);

endmodule

// File: raster_irq.f
logic/raster_pkg.sv
logic/video_timing.sv
logic/raster_counter.sv
logic/raster_unit.sv
logic/irq_latch.sv
logic/raster_irq_top.sv
verif/raster_irq_assertions.sv
verif/raster_irq_checker.sv
verif/raster_irq_tb.sv

// File: verif/raster_irq_assertions.sv
// ==============================
// bound checks on the irq latch
// pending causes, irq drop,
// pixel enable spacing
// ==============================
module raster_irq_assertions #(
    parameter int PXL_DIV = 2 // clk cycles per pixel
) (
    input logic                    clk,
    input logic                    rst,
    input raster_pkg::raster_wr_t  cpu,
    input raster_pkg::video_sync_t sync,
    input logic                    raster_event,
    input logic [1:0]              pend,
    input logic                    irq
);
    timeunit 1ns;
    timeprecision 100ps;
    import raster_pkg::*;

    int fail_cnt = 0; // read by the testbench at the end

    // raster bit only rises after an event rise
    raster_cause: assert property (@(posedge clk) disable iff (rst)
        $rose(pend[IRQ_RASTER_BIT]) |-> $past(raster_event) && !$past(raster_event, 2))
    else begin
        $error("raster pending bit set without a raster event rise one cycle before");
        fail_cnt++;
    end

    // frame bit only rises after a qualified frame start
    frame_cause: assert property (@(posedge clk) disable iff (rst)
        $rose(pend[IRQ_FRAME_BIT]) |-> $past(sync.pxl_cen && sync.frame_start))
    else begin
        $error("frame pending bit set without a frame start one cycle before");
        fail_cnt++;
    end

    // irq only drops after the cpu acknowledges
    irq_drop_on_ack: assert property (@(posedge clk) disable iff (rst)
        $fell(irq) |-> $past(cpu.wr && cpu.addr == REG_IRQ))
    else begin
        $error("irq dropped without an acknowledge write one cycle before");
        fail_cnt++;
    end

    if (PXL_DIV > 1) begin : g_cen
        cen_spacing: assert property (@(posedge clk) disable iff (rst)
            sync.pxl_cen |=> !sync.pxl_cen)
        else begin
            $error("pixel enable high on two consecutive cycles");
            fail_cnt++;
        end
    end

endmodule

// testbench runs the timing generator with a divider of 2
bind irq_latch raster_irq_assertions #(.PXL_DIV(2)) assert_i (
    .clk          (clk),
    .rst          (rst),
    .cpu          (cpu),
    .sync         (sync),
    .raster_event (raster_event),
    .pend         (pend),
    .irq          (irq)
);

// File: verif/raster_irq_checker.sv
// ==============================
// reference model and compare
// timing, counters, event, pending
// bits vs readback and irq
// ==============================
module raster_irq_checker #(
    parameter int H_TOTAL = 16,
    parameter int V_TOTAL = 12,
    parameter int PXL_DIV = 2,
    parameter int CNT_W   = 9
) (
    input  logic                   clk,
    input  logic                   rst,
    input  raster_pkg::raster_wr_t cpu,
    input  logic [15:0]            rd_data,
    input  logic                   rd_valid,
    input  logic                   irq,
    output int                     err_cnt
);
    timeunit 1ns;
    timeprecision 100ps;
    import raster_pkg::*;

    int               m_div;         // clk inside pixel
    int               m_h;           // pixel in line
    int               m_v;           // line in frame
    logic [CNT_W-1:0] m_start [3];
    logic [CNT_W-1:0] m_cnt [3];
    logic             m_en [3];
    logic             m_event;       // registered event level
    logic             m_ev_q;        // event one clk late
    logic [1:0]       m_pend;
    logic             m_rd_valid;
    logic [15:0]      m_rd_data;

    initial err_cnt = 0;

    task automatic report(input string msg);
        err_cnt++;
        $display("mismatch at %0d ns: %s", $time, msg);
    endtask

    task automatic reset_model();
        int i;
        m_div = 0;
        m_h   = 0;
        m_v   = 0;
        for (i = 0; i < 3; i++) begin
            m_start[i] = '0;
            m_cnt[i]   = '0;
            m_en[i]    = 1'b0; // disabled, start 0
        end
        m_event    = 1'b0;
        m_ev_q     = 1'b0;
        m_pend     = 2'b00;
        m_rd_valid = 1'b0;
        m_rd_data  = '0;
    endtask

    // what a read of register a returns from the current state
    function automatic logic [15:0] readback(input raster_reg_e a);
        logic [CNT_W-1:0] v;
        if (a == REG_IRQ) begin
            return {14'd0, m_pend};
        end
        v = m_en[a] ? m_cnt[a] : m_start[a]; // live only when enabled
        return 16'(v);
    endfunction

    // one counter across one clk edge
    task automatic update_counter(input int i, input logic restart, input logic step);
        if (cpu.wr && cpu.addr == raster_reg_e'(i)) begin
            m_start[i] = cpu.data[CNT_W-1:0];
            m_en[i]    = cpu.data[CNT_EN_BIT];
            m_cnt[i]   = cpu.data[CNT_W-1:0];   // load at once
        end else if (!m_en[i] || restart) begin
            m_cnt[i] = m_start[i];              // hold or frame reload
        end else if (step) begin
            m_cnt[i] = m_cnt[i] - 1'b1;         // wraps below zero
        end
    endtask

    always @(posedge clk) begin : step_model
        logic       pxl;
        logic       restart;
        logic       step;
        logic       cond;
        logic [1:0] set_b;
        logic [1:0] clr_b;
        int         i;
        if (rst) begin
            reset_model();
        end else begin
            // dut outputs still hold their values from before this edge
            if (irq !== |m_pend) begin
                report($sformatf("irq %b, pending bits %b", irq, m_pend));
            end
            if (rd_valid !== m_rd_valid) begin
                report($sformatf("rd_valid %b, expected %b", rd_valid, m_rd_valid));
            end else if (m_rd_valid && rd_data !== m_rd_data) begin
                report($sformatf("rd_data %h, expected %h", rd_data, m_rd_data));
            end
            pxl     = m_div == PXL_DIV - 1;
            step    = pxl && m_h == 0;     // line start
            restart = step && m_v == 0;    // frame start
            cond    = m_cnt[2] == 0 && (m_cnt[0] == 0 || m_cnt[1] == 0);
            set_b   = {restart, m_event && !m_ev_q};
            clr_b   = (cpu.wr && cpu.addr == REG_IRQ) ? cpu.data[1:0] : 2'b00;
            m_rd_valid = cpu.rd;
            if (cpu.rd) begin
                m_rd_data = readback(cpu.addr); // state before the edge
            end
            for (i = 0; i < 3; i++) begin
                update_counter(i, restart, step);
            end
            m_ev_q  = m_event;
            m_event = cond;
            m_pend  = (m_pend & ~clr_b) | set_b; // set beats clear
            if (pxl) begin
                m_div = 0;
                if (m_h == H_TOTAL - 1) begin
                    m_h = 0;
                    m_v = (m_v == V_TOTAL - 1) ? 0 : m_v + 1;
                end else begin
                    m_h++;
                end
            end else begin
                m_div++;
            end
        end
    end

endmodule

// File: verif/raster_irq_tb.sv
// ==============================
// raster interrupt testbench
// clock, reset, seeded cpu traffic,
// timeout, closing report
// ==============================
module raster_irq_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import raster_pkg::*;

    localparam int H_TOTAL    = 16;
    localparam int V_TOTAL    = 12;
    localparam int PXL_DIV    = 2;
    localparam int CNT_W      = 9;
    localparam int N_FRAMES   = 12;
    localparam int RST_CYCLES = 4;
    localparam int RUN_CYCLES = N_FRAMES * V_TOTAL * H_TOTAL * PXL_DIV; // 4608
    localparam int TIMEOUT_CYCLES = RUN_CYCLES * 5 / 4 + 240;         // 6000 with margin

    logic        clk = 1'b0;
    logic        rst;
    raster_wr_t  cpu;
    logic [15:0] rd_data;
    logic        rd_valid;
    logic        irq;
    int          mismatch_cnt;
    int          cycle_cnt = 0;
    int          seed = 32'h12d2d19b;

    always #2 clk = ~clk; // 4 ns period

    raster_irq_top #(
        .H_TOTAL (H_TOTAL), .V_TOTAL (V_TOTAL), .PXL_DIV (PXL_DIV), .CNT_W (CNT_W)
    ) dut_i (
        .clk (clk), .rst (rst), .cpu (cpu),
        .rd_data (rd_data), .rd_valid (rd_valid), .irq (irq)
    );

    raster_irq_checker #(
        .H_TOTAL (H_TOTAL), .V_TOTAL (V_TOTAL), .PXL_DIV (PXL_DIV), .CNT_W (CNT_W)
    ) chk_i (
        .clk (clk), .rst (rst), .cpu (cpu), .rd_data (rd_data),
        .rd_valid (rd_valid), .irq (irq), .err_cnt (mismatch_cnt)
    );

    task automatic set_idle();
        cpu = '0;
    endtask

    task automatic write_counter(input int idx, input logic en, input int start);
        cpu                  = '0;
        cpu.wr               = 1'b1;
        cpu.addr             = raster_reg_e'(idx);
        cpu.data[CNT_EN_BIT] = en;
        cpu.data[CNT_W-1:0]  = CNT_W'(start);
    endtask

    task automatic ack_irq(input logic [1:0] bits);
        cpu           = '0;
        cpu.wr        = 1'b1;
        cpu.addr      = REG_IRQ;
        cpu.data[1:0] = bits; // bit 0 raster, bit 1 frame
    endtask

    task automatic read_reg(input raster_reg_e addr);
        cpu      = '0;
        cpu.rd   = 1'b1;
        cpu.addr = addr;
    endtask

    // sparse writes, occasional acks, more frequent reads
    task automatic drive_random();
        int pick;
        int sel;
        pick = $unsigned($random(seed)) % 100;
        sel  = $unsigned($random(seed)) % 4;
        if (pick < 2) begin
            write_counter(sel % 3, pick == 0, $unsigned($random(seed)) % (V_TOTAL + 4));
        end else if (pick < 4) begin
            ack_irq(2'($random(seed)));
        end else if (pick < 14) begin
            read_reg(raster_reg_e'(sel));
        end else begin
            set_idle();
        end
    endtask

    task automatic finish_run(input bit timed_out);
        int assert_cnt;
        assert_cnt = dut_i.latch_i.assert_i.fail_cnt;
        $display("errors: %0d mismatches, %0d assertion failures, %0d timeouts",
                 mismatch_cnt, assert_cnt, timed_out);
        if (timed_out || mismatch_cnt != 0 || assert_cnt != 0) begin
            $display("FAIL: see errors above");
        end else begin
            $display("PASS: all tests");
        end
        $finish;
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            finish_run(1'b1);
        end
    end

    initial begin : stimulus
        int i;
        rst = 1'b1;
        set_idle();
        repeat (RST_CYCLES) @(posedge clk);
        #1 rst = 1'b0;
        for (i = 0; i < 4; i++) begin // every register right after reset
            @(posedge clk);
            #1 read_reg(raster_reg_e'(i));
        end
        @(posedge clk);
        #1 write_counter(0, 1'b1, 4); // counters 0 and 2 meet zero together
        @(posedge clk);
        #1 write_counter(2, 1'b1, 4);
        for (i = 0; i < RUN_CYCLES; i++) begin
            @(posedge clk);
            #1 drive_random();
        end
        @(posedge clk);
        #1 set_idle();
        repeat (4) @(posedge clk); // drain last read
        finish_run(1'b0);
    end

endmodule
